// ==== common/simd_alu_macros.svh ====
// SIMD ALU datapath widths and APB register map
`ifndef SIMD_ALU_MACROS_SVH
`define SIMD_ALU_MACROS_SVH

// Datapath
`define SIMD_ALU_XLEN   64
`define SIMD_ALU_NBYTES 8

// APB port
`define APB_ADDR_W 8
`define APB_DATA_W 32

// Register offsets
`define REG_OPA_LO 8'h00
`define REG_OPA_HI 8'h04
`define REG_OPB_LO 8'h08
`define REG_OPB_HI 8'h0C
`define REG_CTRL   8'h10
`define REG_RES_LO 8'h14
`define REG_RES_HI 8'h18
`define REG_STATUS 8'h1C

`endif

// ==== common/simd_alu_pkg.sv ====
// SIMD ALU types for operand words, opcodes, element widths and byte flags
`include "simd_alu_macros.svh"

package simd_alu_pkg;

  typedef logic [`SIMD_ALU_XLEN-1:0]   elen_t;
  typedef logic [`SIMD_ALU_NBYTES-1:0] byte_flags_t;
  typedef logic [`APB_DATA_W-1:0]      apb_data_t;

  // Opcodes, anything above MSLTU is invalid
  typedef enum logic [4:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SADDU,
    SADD,
    SSUBU,
    SSUB,
    SLL,
    SRL,
    SRA,
    MINU,
    MIN,
    MAXU,
    MAX,
    MSEQ,
    MSLT,
    MSLTU
  } alu_op_e;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Same word seen as elements of each width
  typedef union packed {
    logic [0:0][63:0] e64;
    logic [1:0][31:0] e32;
    logic [3:0][15:0] e16;
    logic [7:0][7:0]  e8;
  } elem_view_t;

  // Byte index bits that lie inside one element
  function automatic logic [2:0] vew_byte_mask(vew_e vew);
    return 3'((4'd1 << vew) - 4'd1);
  endfunction

endpackage

// ==== common/alu_req_if.sv ====
// Request and registered result channel between the register block and the ALU
`timescale 1ns/10ps

interface alu_req_if import simd_alu_pkg::*; ();

  // Request side
  logic        req_valid;
  elen_t       opa;
  elen_t       opb;
  alu_op_e     op;
  vew_e        vew;

  // Result side
  logic        res_valid;
  elen_t       result;
  byte_flags_t vxsat;

  modport regs (
    output req_valid, opa, opb, op, vew,
    input  res_valid, result, vxsat
  );

  modport alu (
    input  req_valid, opa, opb, op, vew,
    output res_valid, result, vxsat
  );

endinterface

// ==== simd_alu/simd_lane_cmp.sv ====
// Per-element less-than and equality flags at every element width
`timescale 1ns/10ps

module simd_lane_cmp import simd_alu_pkg::*; (
  input  elen_t       opa_i,
  input  elen_t       opb_i,
  input  logic        is_signed_i,
  input  vew_e        vew_i,
  output byte_flags_t less_o,
  output byte_flags_t equal_o
);

  elem_view_t va;
  elem_view_t vb;

  assign va = opa_i;
  assign vb = opb_i;

  // Less is B < A, one extra bit carries sign or zero extension
  always_comb begin
    less_o  = '0;
    equal_o = '0;
    unique case (vew_i)
      EW8: for (int e = 0; e < 8; e++) begin
        less_o[e]  = $signed({is_signed_i & vb.e8[e][7], vb.e8[e]}) <
                     $signed({is_signed_i & va.e8[e][7], va.e8[e]});
        equal_o[e] = vb.e8[e] == va.e8[e];
      end
      EW16: for (int e = 0; e < 4; e++) begin
        less_o[2*e +: 2]  = {2{$signed({is_signed_i & vb.e16[e][15], vb.e16[e]}) <
                               $signed({is_signed_i & va.e16[e][15], va.e16[e]})}};
        equal_o[2*e +: 2] = {2{vb.e16[e] == va.e16[e]}};
      end
      EW32: for (int e = 0; e < 2; e++) begin
        less_o[4*e +: 4]  = {4{$signed({is_signed_i & vb.e32[e][31], vb.e32[e]}) <
                               $signed({is_signed_i & va.e32[e][31], va.e32[e]})}};
        equal_o[4*e +: 4] = {4{vb.e32[e] == va.e32[e]}};
      end
      EW64: begin
        less_o  = {8{$signed({is_signed_i & vb.e64[0][63], vb.e64[0]}) <
                     $signed({is_signed_i & va.e64[0][63], va.e64[0]})}};
        equal_o = {8{vb.e64[0] == va.e64[0]}};
      end
    endcase
  end

endmodule

// ==== simd_alu/simd_lane_arith.sv ====
// Per-element wrapping and saturating add and subtract with saturation flags
`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module simd_lane_arith import simd_alu_pkg::*; (
  input  elen_t       opa_i,
  input  elen_t       opb_i,
  input  alu_op_e     op_i,
  input  vew_e        vew_i,
  output elen_t       sum_o,
  output byte_flags_t vxsat_o
);

  logic        is_sub;
  logic        is_sat;
  logic        is_signed;
  logic [2:0]  bmask;
  elen_t       addend;
  elen_t       raw;
  byte_flags_t ovf;

  assign is_sub    = op_i inside {SUB, SSUBU, SSUB};
  assign is_sat    = op_i inside {SADDU, SADD, SSUBU, SSUB};
  assign is_signed = op_i inside {SADD, SSUB};
  assign bmask     = vew_byte_mask(vew_i);

  // B - A done as B + ~A + 1
  assign addend = is_sub ? ~opa_i : opa_i;

  //////////////////////////////
  // Byte ripple
  //////////////////////////////

  // Carry restarts at the first byte of every element
  always_comb begin
    logic       carry;
    logic [8:0] bsum;
    logic       msb_cin;
    carry = 1'b0;
    for (int b = 0; b < `SIMD_ALU_NBYTES; b++) begin
      if ((b & int'(bmask)) == 0) begin
        carry = is_sub;
      end
      bsum          = {1'b0, opb_i[8*b +: 8]} + {1'b0, addend[8*b +: 8]} + 9'(carry);
      raw[8*b +: 8] = bsum[7:0];
      msb_cin       = bsum[7] ^ opb_i[8*b+7] ^ addend[8*b+7];
      // only the element's top byte gives a real overflow
      ovf[b]        = is_signed ? (msb_cin ^ bsum[8]) : (bsum[8] ^ is_sub);
      carry         = bsum[8];
    end
  end

  //////////////////////////////
  // Saturation
  //////////////////////////////

  // Signed overflow direction follows the sign of B
  always_comb begin
    int   top;
    logic neg;
    for (int b = 0; b < `SIMD_ALU_NBYTES; b++) begin
      top        = b | int'(bmask);
      neg        = opb_i[8*top+7];
      vxsat_o[b] = is_sat & ovf[top];
      if (!vxsat_o[b]) begin
        sum_o[8*b +: 8] = raw[8*b +: 8];
      end else if (!is_signed) begin
        sum_o[8*b +: 8] = is_sub ? 8'h00 : 8'hFF;
      end else if (b == top) begin
        sum_o[8*b +: 8] = neg ? 8'h80 : 8'h7F;
      end else begin
        sum_o[8*b +: 8] = neg ? 8'h00 : 8'hFF;
      end
    end
  end

endmodule

// ==== simd_alu/simd_lane_shift.sv ====
// Per-element logical and arithmetic shifts of B by the amounts in A
`timescale 1ns/10ps

module simd_lane_shift import simd_alu_pkg::*; (
  input  elen_t   opa_i,
  input  elen_t   opb_i,
  input  alu_op_e op_i,
  input  vew_e    vew_i,
  output elen_t   shifted_o
);

  elem_view_t va;
  elem_view_t vb;
  elem_view_t res;
  logic       is_sll;
  logic       is_sra;

  assign va        = opa_i;
  assign vb        = opb_i;
  assign is_sll    = op_i == SLL;
  assign is_sra    = op_i == SRA;
  assign shifted_o = res;

  // Amount is the low log2(width) bits of each A element
  always_comb begin
    res = '0;
    unique case (vew_i)
      EW8: for (int e = 0; e < 8; e++) begin
        if (is_sll)
          res.e8[e] = vb.e8[e] << va.e8[e][2:0];
        else if (is_sra)
          res.e8[e] = $signed(vb.e8[e]) >>> va.e8[e][2:0];
        else
          res.e8[e] = vb.e8[e] >> va.e8[e][2:0];
      end
      EW16: for (int e = 0; e < 4; e++) begin
        if (is_sll)
          res.e16[e] = vb.e16[e] << va.e16[e][3:0];
        else if (is_sra)
          res.e16[e] = $signed(vb.e16[e]) >>> va.e16[e][3:0];
        else
          res.e16[e] = vb.e16[e] >> va.e16[e][3:0];
      end
      EW32: for (int e = 0; e < 2; e++) begin
        if (is_sll)
          res.e32[e] = vb.e32[e] << va.e32[e][4:0];
        else if (is_sra)
          res.e32[e] = $signed(vb.e32[e]) >>> va.e32[e][4:0];
        else
          res.e32[e] = vb.e32[e] >> va.e32[e][4:0];
      end
      EW64: begin
        if (is_sll)
          res.e64[0] = vb.e64[0] << va.e64[0][5:0];
        else if (is_sra)
          res.e64[0] = $signed(vb.e64[0]) >>> va.e64[0][5:0];
        else
          res.e64[0] = vb.e64[0] >> va.e64[0][5:0];
      end
    endcase
  end

endmodule

// ==== simd_alu/simd_alu.sv ====
// SIMD ALU with opcode decode, per-element result select and result register
`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module simd_alu import simd_alu_pkg::*; (
  input logic    clk_i,
  input logic    arst_n_i,
  alu_req_if.alu req
);

  logic        is_signed;
  logic        is_max;
  logic [2:0]  bmask;
  byte_flags_t less;
  byte_flags_t equal;
  byte_flags_t vxsat;
  elen_t       sum;
  elen_t       shifted;
  elen_t       res_d;
  elen_t       result_q;
  byte_flags_t vxsat_q;
  logic        res_valid_q;

  assign is_signed = req.op inside {MIN, MAX, MSLT};
  assign is_max    = req.op inside {MAXU, MAX};
  assign bmask     = vew_byte_mask(req.vew);

  simd_lane_cmp simd_lane_cmp_i (
    .opa_i       (req.opa),
    .opb_i       (req.opb),
    .is_signed_i (is_signed),
    .vew_i       (req.vew),
    .less_o      (less),
    .equal_o     (equal)
  );

  simd_lane_arith simd_lane_arith_i (
    .opa_i   (req.opa),
    .opb_i   (req.opb),
    .op_i    (req.op),
    .vew_i   (req.vew),
    .sum_o   (sum),
    .vxsat_o (vxsat)
  );

  simd_lane_shift simd_lane_shift_i (
    .opa_i     (req.opa),
    .opb_i     (req.opb),
    .op_i      (req.op),
    .vew_i     (req.vew),
    .shifted_o (shifted)
  );

  //////////////////////////////
  // Result select
  //////////////////////////////

  // Flags are replicated per byte, so MIN/MAX can pick byte by byte
  always_comb begin
    res_d = '0;
    unique case (req.op)
      AND: res_d = req.opa & req.opb;
      OR:  res_d = req.opa | req.opb;
      XOR: res_d = req.opa ^ req.opb;
      ADD, SUB, SADDU, SADD, SSUBU, SSUB: res_d = sum;
      SLL, SRL, SRA: res_d = shifted;
      MINU, MIN, MAXU, MAX: begin
        for (int b = 0; b < `SIMD_ALU_NBYTES; b++) begin
          res_d[8*b +: 8] = (less[b] ^ is_max) ? req.opb[8*b +: 8] : req.opa[8*b +: 8];
        end
      end
      MSEQ, MSLT, MSLTU: begin
        // Flag lands in bit 0 of each element
        for (int b = 0; b < `SIMD_ALU_NBYTES; b++) begin
          if ((b & int'(bmask)) == 0) begin
            res_d[8*b] = (req.op == MSEQ) ? equal[b] : less[b];
          end
        end
      end
      default: res_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_valid_q <= 1'b0;
      result_q    <= '0;
      vxsat_q     <= '0;
    end else begin
      res_valid_q <= req.req_valid;
      if (req.req_valid) begin
        result_q <= res_d;
        vxsat_q  <= vxsat;
      end
    end
  end

  assign req.res_valid = res_valid_q;
  assign req.result    = result_q;
  assign req.vxsat     = vxsat_q;

endmodule

// ==== source/apb_alu_regs.sv ====
// APB slave holding the ALU operands, control word, result and status
`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module apb_alu_regs import simd_alu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  apb_data_t              pwdata_i,
  output apb_data_t              prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  alu_req_if.regs                req
);

  logic        access;
  logic        addr_ok;
  logic        ro_hit;
  logic        op_ok;
  logic        err;
  logic        wr_en;
  logic        ctrl_wr;
  elen_t       opa_q;
  elen_t       opb_q;
  elen_t       res_q;
  alu_op_e     op_q;
  vew_e        vew_q;
  byte_flags_t sat_q;
  logic        valid_q;

  //////////////////////////////
  // Access decode
  //////////////////////////////

  assign access    = psel_i & penable_i;
  assign addr_ok   = (paddr_i[1:0] == 2'b00) && (paddr_i <= `REG_STATUS);
  assign ro_hit    = paddr_i inside {`REG_RES_LO, `REG_RES_HI, `REG_STATUS};
  assign op_ok     = pwdata_i[4:0] <= 5'(MSLTU);
  assign err       = !addr_ok || (pwrite_i && (ro_hit || (paddr_i == `REG_CTRL && !op_ok)));
  assign pslverr_o = access & err;
  // No wait states
  assign pready_o  = 1'b1;
  assign wr_en     = access & pwrite_i & ~err;
  assign ctrl_wr   = wr_en && (paddr_i == `REG_CTRL);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      opa_q <= '0;
      opb_q <= '0;
      op_q  <= ADD;
      vew_q <= EW8;
    end else if (wr_en) begin
      unique case (paddr_i)
        `REG_OPA_LO: opa_q[31:0]  <= pwdata_i;
        `REG_OPA_HI: opa_q[63:32] <= pwdata_i;
        `REG_OPB_LO: opb_q[31:0]  <= pwdata_i;
        `REG_OPB_HI: opb_q[63:32] <= pwdata_i;
        `REG_CTRL: begin
          op_q  <= alu_op_e'(pwdata_i[4:0]);
          vew_q <= vew_e'(pwdata_i[9:8]);
        end
        default: ;
      endcase
    end
  end

  // Result capture one cycle after the request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_q   <= '0;
      sat_q   <= '0;
      valid_q <= 1'b0;
    end else if (req.res_valid) begin
      res_q   <= req.result;
      sat_q   <= req.vxsat;
      valid_q <= 1'b1;
    end
  end

  always_comb begin
    prdata_o = '0;
    if (access && !pwrite_i && addr_ok) begin
      unique case (paddr_i)
        `REG_OPA_LO: prdata_o = opa_q[31:0];
        `REG_OPA_HI: prdata_o = opa_q[63:32];
        `REG_OPB_LO: prdata_o = opb_q[31:0];
        `REG_OPB_HI: prdata_o = opb_q[63:32];
        `REG_CTRL:   prdata_o = {22'b0, vew_q, 3'b0, op_q};
        `REG_RES_LO: prdata_o = res_q[31:0];
        `REG_RES_HI: prdata_o = res_q[63:32];
        `REG_STATUS: prdata_o = {23'b0, valid_q, sat_q};
        default: ;
      endcase
    end
  end

  // CTRL data goes straight to the ALU during its write
  assign req.req_valid = ctrl_wr;
  assign req.opa       = opa_q;
  assign req.opb       = opb_q;
  assign req.op        = ctrl_wr ? alu_op_e'(pwdata_i[4:0]) : op_q;
  assign req.vew       = ctrl_wr ? vew_e'(pwdata_i[9:8]) : vew_q;

endmodule

// ==== source/alu_top.sv ====
// Top level joining the APB register block to the SIMD ALU
`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module alu_top import simd_alu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  apb_data_t              pwdata_i,
  output apb_data_t              prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  alu_req_if alu_req ();

  apb_alu_regs apb_alu_regs_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .req       (alu_req)
  );

  simd_alu simd_alu_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req      (alu_req)
  );

endmodule

// ==== tb/alu_top_chk.sv ====
// APB protocol and result timing assertions bound to the ALU top level
`timescale 1ns/10ps

module alu_top_chk (
  input logic clk_i,
  input logic arst_n_i,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i,
  input logic req_valid_i,
  input logic res_valid_i
);

  // No wait states
  a_pready_high: assert property (@(posedge clk_i) disable iff (!arst_n_i) pready_i)
    else $error("pready went low");

  a_res_follows_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) res_valid_i == $past(req_valid_i))
    else $error("res_valid did not follow req_valid by one cycle");

  a_slverr_in_access: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) pslverr_i |-> (psel_i && penable_i))
    else $error("pslverr high outside an access cycle");

endmodule

bind alu_top alu_top_chk alu_top_chk_i (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .psel_i      (psel_i),
  .penable_i   (penable_i),
  .pready_i    (pready_o),
  .pslverr_i   (pslverr_o),
  .req_valid_i (alu_req.req_valid),
  .res_valid_i (alu_req.res_valid)
);

// ==== tb/tb_alu_top.sv ====
// Testbench for the APB SIMD ALU with random stimulus and a reference model
`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module tb_alu_top import simd_alu_pkg::*; ();

  // Eight transfers per run_op call plus register and error traffic
  localparam int N_XFERS    = 12 + 8 * (1000 + 200 + 48 + 112 + 1) + 13;
  localparam int MAX_CYCLES = 4 * N_XFERS * 2;

  logic        clk;
  logic        arst_n;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  int          seed;
  int          cycles;
  int          n_checks;
  int          n_errors;
  int          t_checks;
  int          t_errors;
  alu_op_e     basic_ops [5] = '{AND, OR, XOR, ADD, SUB};
  alu_op_e     sat_ops   [4] = '{SADDU, SADD, SSUBU, SSUB};
  alu_op_e     shift_ops [3] = '{SLL, SRL, SRA};
  alu_op_e     cmp_ops   [7] = '{MIN, MINU, MAX, MAXU, MSEQ, MSLT, MSLTU};

  alu_top alu_top_i (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic signed [65:0] sext(logic [63:0] x, int w);
    logic [65:0] v;
    v = {2'b00, x};
    if (x[w-1]) v = v | ~((66'd1 << w) - 66'd1);
    return $signed(v);
  endfunction

  // Returns {saturation flags, result} with B as the first operand of each rule
  function automatic logic [71:0] model_op(logic [63:0] a, logic [63:0] b, alu_op_e op,
                                           vew_e vew);
    int                 w;
    int                 nb;
    int                 amt;
    logic [63:0]        mask;
    logic [63:0]        ea;
    logic [63:0]        eb;
    logic [63:0]        r;
    logic [63:0]        res;
    logic [7:0]         sat;
    logic [65:0]        u;
    logic signed [65:0] sa;
    logic signed [65:0] sb;
    logic signed [65:0] s;
    logic signed [65:0] smax;
    logic signed [65:0] smin;
    logic               flag;
    w    = 8 << int'(vew);
    nb   = w / 8;
    mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    smax = (66'sd1 <<< (w - 1)) - 66'sd1;
    smin = -(66'sd1 <<< (w - 1));
    res  = '0;
    sat  = '0;
    for (int e = 0; e < 64 / w; e++) begin
      ea   = (a >> (e * w)) & mask;
      eb   = (b >> (e * w)) & mask;
      sa   = sext(ea, w);
      sb   = sext(eb, w);
      amt  = int'(ea[31:0]) & (w - 1);
      flag = 1'b0;
      case (op)
        ADD:   r = eb + ea;
        SUB:   r = eb - ea;
        AND:   r = eb & ea;
        OR:    r = eb | ea;
        XOR:   r = eb ^ ea;
        SADDU: begin
          u    = {2'b00, eb} + {2'b00, ea};
          flag = u > {2'b00, mask};
          r    = flag ? mask : u[63:0];
        end
        SSUBU: begin
          flag = eb < ea;
          r    = flag ? 64'd0 : eb - ea;
        end
        SADD, SSUB: begin
          s    = (op == SADD) ? sb + sa : sb - sa;
          flag = (s > smax) || (s < smin);
          r    = (s > smax) ? smax[63:0] : ((s < smin) ? smin[63:0] : s[63:0]);
        end
        SLL:   r = eb << amt;
        SRL:   r = eb >> amt;
        SRA: begin
          s = sb >>> amt;
          r = s[63:0];
        end
        MINU:  r = (eb < ea) ? eb : ea;
        MAXU:  r = (eb > ea) ? eb : ea;
        MIN:   r = (sb < sa) ? eb : ea;
        MAX:   r = (sb > sa) ? eb : ea;
        MSEQ:  r = {63'd0, eb == ea};
        MSLT:  r = {63'd0, sb < sa};
        MSLTU: r = {63'd0, eb < ea};
        default: r = '0;
      endcase
      res = res | ((r & mask) << (e * w));
      if (flag) sat = sat | (((8'd1 << nb) - 8'd1) << (e * nb));
    end
    return {sat, res};
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [63:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Bytes pulled toward the ends of the signed and unsigned ranges
  function automatic logic [63:0] biased_word();
    logic [63:0] v;
    logic [31:0] r;
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      case (r[2:0])
        3'd0: v[8*i +: 8] = 8'h00;
        3'd1: v[8*i +: 8] = 8'h7F;
        3'd2: v[8*i +: 8] = 8'h80;
        3'd3: v[8*i +: 8] = 8'hFF;
        default: v[8*i +: 8] = r[15:8];
      endcase
    end
    return v;
  endfunction

  function automatic logic [63:0] sign_bits(vew_e vew);
    logic [63:0] m;
    int          w;
    m = '0;
    w = 8 << int'(vew);
    for (int i = w - 1; i < 64; i += w) m[i] = 1'b1;
    return m;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Called just after a rising edge; returns at the same point of a later cycle
  task automatic apb_xfer(input logic [7:0] addr, input logic wr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic run_op(input logic [63:0] a, input logic [63:0] b, input alu_op_e op,
                        input vew_e vew);
    apb_data_t   lo;
    apb_data_t   hi;
    apb_data_t   st;
    apb_data_t   unused;
    logic        err;
    logic        err_any;
    logic [71:0] exp;
    string       tag;
    err_any = 1'b0;
    tag     = $sformatf("%s ew%0d", op.name(), 8 << int'(vew));
    apb_xfer(`REG_OPA_LO, 1'b1, a[31:0], unused, err);
    err_any |= err;
    apb_xfer(`REG_OPA_HI, 1'b1, a[63:32], unused, err);
    err_any |= err;
    apb_xfer(`REG_OPB_LO, 1'b1, b[31:0], unused, err);
    err_any |= err;
    apb_xfer(`REG_OPB_HI, 1'b1, b[63:32], unused, err);
    err_any |= err;
    apb_xfer(`REG_CTRL, 1'b1, {22'd0, vew, 3'd0, op}, unused, err);
    err_any |= err;
    apb_xfer(`REG_RES_LO, 1'b0, '0, lo, err);
    err_any |= err;
    apb_xfer(`REG_RES_HI, 1'b0, '0, hi, err);
    err_any |= err;
    apb_xfer(`REG_STATUS, 1'b0, '0, st, err);
    err_any |= err;
    exp = model_op(a, b, op, vew);
    check_value({"pslverr ", tag}, 64'(err_any), 64'd0);
    check_value({"result ", tag}, {hi, lo}, exp[63:0]);
    check_value({"status ", tag}, 64'(st), {55'd0, 1'b1, exp[71:64]});
  endtask

  task automatic start_test();
    t_checks = n_checks;
    t_errors = n_errors;
  endtask

  task automatic end_test(input string name);
    $display("Test %s: %0d checks, %0d errors", name, n_checks - t_checks, n_errors - t_errors);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    apb_data_t   rd;
    apb_data_t   exp_regs [8];
    logic [71:0] exp;
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] r;
    logic        err;
    vew_e        vew;
    seed     = 39645;
    cycles   = 0;
    n_checks = 0;
    n_errors = 0;
    clk      = 1'b0;
    arst_n   = 1'b0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;

    start_test();
    for (int i = 0; i < 4; i++) begin
      apb_xfer(8'(`REG_CTRL + 4 * i), 1'b0, '0, rd, err);
      check_value($sformatf("reset value reg 0x%h", 8'(`REG_CTRL + 4 * i)), 64'(rd), 64'd0);
    end
    a = rand_word();
    b = rand_word();
    apb_xfer(`REG_OPA_LO, 1'b1, a[31:0], rd, err);
    apb_xfer(`REG_OPA_HI, 1'b1, a[63:32], rd, err);
    apb_xfer(`REG_OPB_LO, 1'b1, b[31:0], rd, err);
    apb_xfer(`REG_OPB_HI, 1'b1, b[63:32], rd, err);
    for (int i = 0; i < 4; i++) begin
      apb_xfer(8'(4 * i), 1'b0, '0, rd, err);
      check_value($sformatf("readback reg 0x%h", 8'(4 * i)), 64'(rd),
                  64'((i < 2) ? a[32*i +: 32] : b[32*(i-2) +: 32]));
    end
    end_test("1 registers");

    start_test();
    for (int i = 0; i < 200; i++) begin
      a = rand_word();
      b = rand_word();
      r = $random(seed);
      for (int k = 0; k < 5; k++) run_op(a, b, basic_ops[k], vew_e'(r[1:0]));
    end
    end_test("2 logic and wrapping arithmetic");

    start_test();
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      run_op(biased_word(), biased_word(), sat_ops[r[3:2]], vew_e'(r[1:0]));
    end
    end_test("3 saturating arithmetic");

    start_test();
    for (int k = 0; k < 3; k++) begin
      for (int v = 0; v < 4; v++) begin
        run_op(64'd0, rand_word(), shift_ops[k], vew_e'(v));
        run_op('1, rand_word(), shift_ops[k], vew_e'(v));
        run_op(rand_word(), rand_word(), shift_ops[k], vew_e'(v));
        run_op(rand_word(), rand_word(), shift_ops[k], vew_e'(v));
      end
    end
    end_test("4 shifts");

    start_test();
    for (int k = 0; k < 7; k++) begin
      for (int v = 0; v < 4; v++) begin
        vew = vew_e'(v);
        a   = biased_word();
        run_op(a, biased_word(), cmp_ops[k], vew);
        run_op(a, a, cmp_ops[k], vew);
        run_op(a, a ^ sign_bits(vew), cmp_ops[k], vew);
        run_op(rand_word(), rand_word(), cmp_ops[k], vew);
      end
    end
    end_test("5 min, max and compares");

    start_test();
    a   = biased_word();
    b   = biased_word();
    exp = model_op(a, b, SADD, EW8);
    run_op(a, b, SADD, EW8);
    // Register contents that every rejected transfer must leave alone
    exp_regs[0] = a[31:0];
    exp_regs[1] = a[63:32];
    exp_regs[2] = b[31:0];
    exp_regs[3] = b[63:32];
    exp_regs[4] = {22'd0, EW8, 3'd0, SADD};
    exp_regs[5] = exp[31:0];
    exp_regs[6] = exp[63:32];
    exp_regs[7] = {23'd0, 1'b1, exp[71:64]};
    apb_xfer(`REG_RES_LO, 1'b1, $random(seed), rd, err);
    check_value("pslverr write RES_LO", 64'(err), 64'd1);
    apb_xfer(8'h20, 1'b1, $random(seed), rd, err);
    check_value("pslverr write 0x20", 64'(err), 64'd1);
    apb_xfer(8'h20, 1'b0, '0, rd, err);
    check_value("pslverr read 0x20", 64'(err), 64'd1);
    apb_xfer(8'h02, 1'b1, $random(seed), rd, err);
    check_value("pslverr unaligned write", 64'(err), 64'd1);
    apb_xfer(`REG_CTRL, 1'b1, 32'h0000_0313, rd, err);
    check_value("pslverr invalid opcode", 64'(err), 64'd1);
    for (int i = 0; i < 8; i++) begin
      apb_xfer(8'(4 * i), 1'b0, '0, rd, err);
      check_value($sformatf("unchanged reg 0x%h", 8'(4 * i)), 64'(rd), 64'(exp_regs[i]));
    end
    end_test("6 slave errors");

    $display("Total: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+common
common/simd_alu_pkg.sv
common/alu_req_if.sv
simd_alu/simd_lane_cmp.sv
simd_alu/simd_lane_arith.sv
simd_alu/simd_lane_shift.sv
simd_alu/simd_alu.sv
source/apb_alu_regs.sv
source/alu_top.sv
tb/alu_top_chk.sv
tb/tb_alu_top.sv

// ==== Makefile ====
TOP  := tb_alu_top
SRCS := $(filter-out +%,$(shell cat compile.f)) common/simd_alu_macros.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 -f compile.f --top-module $(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf obj_dir
